// ==== ball_report_ctrl.sv ====
module ball_report_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ball_send_trigger,
    input  game_pkg::ball_state_t ball,
    input  logic                  ball_moving_left,
    output link_pkg::i2c_req_t    req,
    input  link_pkg::i2c_rsp_t    rsp,
    output logic                  busy,
    output logic [7:0]            status_led
);
    import link_pkg::*;
    import game_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_start_wait,
        s_wait,
        s_send_addr,
        s_send_data,
        s_stop,
        s_done
    } state_t;

    state_t      state, state_next;
    logic [2:0]  byte_cnt, byte_cnt_next;  // 0 is the address byte
    ball_state_t snap;
    logic [7:0]  tx_data;
    logic        take;
    logic        frame_sent;

    // engine still finishing an aborted frame keeps ready low
    assign take       = ball_send_trigger && rsp.ready;
    assign frame_sent = (byte_cnt == 3'(ball_data_bytes + 1));
    assign busy       = (state != s_idle);
    assign status_led = 8'd1 << state;

    always_ff @(posedge clk) begin
        if (state == s_idle && take) begin
            snap <= ball;  // frozen for the whole frame
        end
    end

    always_comb begin
        case (byte_cnt)
            3'd0:    tx_data = ball_slave_addr;
            3'd1:    tx_data = {snap.ball_y[9:8], 6'b0};
            3'd2:    tx_data = snap.ball_y[7:0];
            default: tx_data = snap.ball_vy;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= s_idle;
            byte_cnt <= '0;
        end else begin
            state    <= state_next;
            byte_cnt <= byte_cnt_next;
        end
    end

    always_comb begin
        state_next    = state;
        byte_cnt_next = byte_cnt;
        req           = '0;
        req.data      = tx_data;

        case (state)
            s_idle: begin
                byte_cnt_next = '0;
                if (take) begin
                    state_next = s_start_wait;
                end
            end
            s_start_wait: begin
                req.start = 1'b1;
                req.en    = 1'b1;
                if (!rsp.ready) begin
                    state_next = s_wait;
                end
            end
            s_wait: begin
                req.en   = 1'b1;  // next command already valid here
                req.stop = frame_sent;
                if (rsp.nack) begin
                    state_next = s_idle;
                end else if (rsp.ready) begin
                    if (frame_sent) begin
                        state_next = s_stop;
                    end else if (byte_cnt == 3'd0) begin
                        state_next = s_send_addr;
                    end else begin
                        state_next = s_send_data;
                    end
                end
            end
            s_send_addr, s_send_data: begin
                req.en = 1'b1;
                if (!rsp.ready) begin
                    state_next    = s_wait;
                    byte_cnt_next = byte_cnt + 3'd1;
                end
            end
            s_stop: begin
                req.en   = 1'b1;
                req.stop = 1'b1;
                if (!rsp.ready) begin
                    state_next = s_done;
                end
            end
            s_done: begin
                if (rsp.ready) begin
                    state_next = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase

        // ball turned back, engine closes the bus after the current byte
        if (ball_moving_left && state != s_idle) begin
            state_next = s_idle;
        end
    end

endmodule

// ==== game_pkg.sv ====
package game_pkg;

    // ball as it leaves this screen
    typedef struct packed {
        logic [9:0] ball_y;
        logic [7:0] ball_vy;
    } ball_state_t;

    typedef struct packed {
        logic [7:0] score_left;
        logic [7:0] score_right;
    } score_state_t;

    // address bytes, write bit already in bit 0
    localparam logic [7:0] ball_slave_addr  = 8'haa;
    localparam logic [7:0] score_slave_addr = 8'hac;

    // payload bytes after the address
    localparam int ball_data_bytes  = 3;
    localparam int score_data_bytes = 2;

endpackage

// ==== i2c_arbiter.sv ====
module i2c_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  link_pkg::i2c_req_t req_ball,
    input  link_pkg::i2c_req_t req_score,
    output link_pkg::i2c_rsp_t rsp_ball,
    output link_pkg::i2c_rsp_t rsp_score,
    output link_pkg::i2c_req_t req_bus,
    input  link_pkg::i2c_rsp_t rsp_bus,
    input  logic               bus_idle
);
    import link_pkg::*;

    typedef enum logic [1:0] {grant_none, grant_ball, grant_score} grant_t;

    grant_t grant;   // owner for the frame in flight
    grant_t pick;
    grant_t owner;
    logic   ball_ask, score_ask;

    assign ball_ask  = req_ball.en && req_ball.start;
    assign score_ask = req_score.en && req_score.start;

    // ball first on a tie
    always_comb begin
        if (ball_ask) begin
            pick = grant_ball;
        end else if (score_ask) begin
            pick = grant_score;
        end else begin
            pick = grant_none;
        end
    end

    // engine takes a start in the same cycle, so route the fresh pick while idle
    assign owner = bus_idle ? pick : grant;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant <= grant_none;
        end else if (bus_idle) begin
            grant <= pick;  // frozen until the stop completes
        end
    end

    always_comb begin
        req_bus   = '0;
        rsp_ball  = i2c_rsp_idle;
        rsp_score = i2c_rsp_idle;
        case (owner)
            grant_ball: begin
                req_bus  = req_ball;
                rsp_ball = rsp_bus;
            end
            grant_score: begin
                req_bus   = req_score;
                rsp_score = rsp_bus;
            end
            default: ;
        endcase
    end

endmodule

// ==== i2c_link_chk.sv ====
module i2c_link_chk (
    input logic       clk,
    input logic       reset,
    input logic       bus_idle,
    input logic       scl_oe,
    input logic       sda_oe,
    input logic       tx_done,
    input logic [1:0] grant
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assert_fails = 0;

    // idle bus has both lines released, sda already high before idle
    a_scl_idle: assert property (@(posedge clk) disable iff (reset)
                                 bus_idle |-> !scl_oe && $past(!sda_oe))
        else begin
            $error("bus idle without scl and sda released after the stop");
            assert_fails++;
        end

    // a peer owns every frame, unchanged until the stop completes
    a_grant_hold: assert property (@(posedge clk) disable iff (reset)
                                   !bus_idle |=> bus_idle || (grant != 2'd0 && $stable(grant)))
        else begin
            $error("grant missing or changed while a frame was on the bus");
            assert_fails++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) tx_done |=> !tx_done)
        else begin
            $error("tx_done high for more than one clock");
            assert_fails++;
        end

endmodule

bind i2c_link_top i2c_link_chk u_chk (
    .clk, .reset, .bus_idle, .scl_oe, .sda_oe, .tx_done(rsp_bus.tx_done), .grant(u_arb.grant)
);

// ==== i2c_link_top.sv ====
module i2c_link_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ball_send_trigger,
    input  game_pkg::ball_state_t  ball,
    input  logic                   ball_moving_left,
    input  logic                   score_send_trigger,
    input  game_pkg::score_state_t score,
    output logic                   scl_oe,
    output logic                   sda_oe,
    input  logic                   sda_in,
    output logic                   ball_busy,
    output logic                   score_busy,
    output logic                   nack_flag,
    output logic [7:0]             status_led
);
    import link_pkg::*;

    i2c_req_t req_ball, req_score, req_bus;
    i2c_rsp_t rsp_ball, rsp_score, rsp_bus;
    logic     bus_idle;

    assign nack_flag = rsp_bus.nack;

    ball_report_ctrl u_ball (.clk, .reset, .ball_send_trigger, .ball, .ball_moving_left,
        .req(req_ball), .rsp(rsp_ball), .busy(ball_busy), .status_led);

    score_report_ctrl u_score (.clk, .reset, .score_send_trigger, .score,
        .req(req_score), .rsp(rsp_score), .busy(score_busy));

    i2c_arbiter u_arb (.clk, .reset, .req_ball, .req_score, .rsp_ball, .rsp_score,
        .req_bus, .rsp_bus, .bus_idle);

    i2c_master u_master (.clk, .reset, .req(req_bus), .rsp(rsp_bus), .bus_idle,
        .scl_oe, .sda_oe, .sda_in);

endmodule

// ==== i2c_master.sv ====
module i2c_master (
    input  logic               clk,
    input  logic               reset,
    input  link_pkg::i2c_req_t req,
    output link_pkg::i2c_rsp_t rsp,
    output logic               bus_idle,
    output logic               scl_oe,
    output logic               sda_oe,
    input  logic               sda_in
);
    import link_pkg::*;

    typedef enum logic [2:0] {st_idle, st_start, st_bit, st_ack, st_hold, st_stop} state_t;

    localparam int cnt_w = $clog2(i2c_quarter_cycles);

    state_t           state;
    logic [cnt_w-1:0] clk_cnt;
    logic [1:0]       quarter;
    logic [2:0]       bit_cnt;
    logic             addr_phase;  // first byte after start
    logic             ack_high;
    logic             quarter_end, phase_end;
    i2c_byte_u        tx_byte, load_byte;

    assign quarter_end = (clk_cnt == cnt_w'(i2c_quarter_cycles - 1));
    assign phase_end   = quarter_end && (quarter == 2'd3);
    assign bus_idle    = (state == st_idle);

    // reads are not supported, force the write bit on the address
    always_comb begin
        load_byte.raw = req.data;
        if (addr_phase) begin
            load_byte.addr_view.rw = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_hold) begin
            tx_byte <= load_byte;
        end else if (state == st_bit && phase_end) begin
            tx_byte.raw <= {tx_byte.raw[6:0], 1'b0};  // msb first
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= st_idle;
            clk_cnt    <= '0;
            quarter    <= '0;
            bit_cnt    <= '0;
            addr_phase <= 1'b0;
            ack_high   <= 1'b0;
            rsp        <= i2c_rsp_idle;
        end else begin
            rsp.tx_done <= 1'b0;
            rsp.nack    <= 1'b0;

            if (state == st_idle || state == st_hold) begin
                clk_cnt <= '0;
                quarter <= '0;
            end else if (quarter_end) begin
                clk_cnt <= '0;
                quarter <= quarter + 2'd1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end

            case (state)
                st_idle: begin
                    if (req.en && req.start) begin
                        state     <= st_start;
                        rsp.ready <= 1'b0;
                    end
                end
                st_start: begin
                    if (phase_end) begin
                        addr_phase <= 1'b1;
                        if (req.en) begin
                            state     <= st_hold;
                            rsp.ready <= 1'b1;
                        end else begin
                            state <= st_stop;
                        end
                    end
                end
                st_hold: begin
                    rsp.ready <= 1'b0;
                    // no repeated start, so a start here closes the frame too
                    if (!req.en || req.stop || req.start) begin
                        state <= st_stop;
                    end else begin
                        state      <= st_bit;
                        bit_cnt    <= '0;
                        addr_phase <= 1'b0;
                    end
                end
                st_bit: begin
                    if (phase_end) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_ack;
                        end
                    end
                end
                st_ack: begin
                    if (quarter == 2'd1 && quarter_end) begin
                        ack_high <= sda_in;  // mid scl high
                    end
                    if (phase_end) begin
                        rsp.tx_done <= 1'b1;
                        if (ack_high) begin
                            rsp.nack <= 1'b1;
                            state    <= st_stop;
                        end else if (!req.en) begin
                            state <= st_stop;
                        end else begin
                            state     <= st_hold;
                            rsp.ready <= 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (phase_end) begin
                        state     <= st_idle;
                        rsp.ready <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // sda only moves while scl is low, except for start and stop
    always_comb begin
        scl_oe = 1'b0;
        sda_oe = 1'b0;
        case (state)
            st_start: begin
                scl_oe = (quarter == 2'd3);
                sda_oe = (quarter != 2'd0);
            end
            st_bit: begin
                scl_oe = (quarter == 2'd0) || (quarter == 2'd3);
                sda_oe = ~tx_byte.raw[7];
            end
            st_ack:  scl_oe = (quarter == 2'd0) || (quarter == 2'd3);
            st_hold: scl_oe = 1'b1;
            st_stop: begin
                scl_oe = (quarter == 2'd0);
                sda_oe = (quarter != 2'd3);  // sda rises in the last quarter
            end
            default: ;
        endcase
    end

endmodule

// ==== link_pkg.sv ====
package link_pkg;

    localparam int i2c_quarter_cycles = 4;  // one scl bit is 4 quarters

    // command from a report sequencer
    typedef struct packed {
        logic       start;
        logic       stop;
        logic       en;
        logic [7:0] data;
    } i2c_req_t;

    // engine status back to the sequencer
    typedef struct packed {
        logic ready;
        logic tx_done;
        logic nack;
    } i2c_rsp_t;

    typedef struct packed {
        logic [6:0] addr;
        logic       rw;     // 0 = write
    } i2c_addr_view_t;

    typedef union packed {
        i2c_addr_view_t addr_view;
        logic [7:0]     raw;
    } i2c_byte_u;

    localparam i2c_rsp_t i2c_rsp_idle = '{ready: 1'b1, tx_done: 1'b0, nack: 1'b0};

endpackage

// ==== project.f ====
link_pkg.sv
game_pkg.sv
ball_report_ctrl.sv
score_report_ctrl.sv
i2c_arbiter.sv
i2c_master.sv
i2c_link_top.sv
i2c_link_chk.sv
tb_i2c_link.sv

// ==== score_report_ctrl.sv ====
module score_report_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   score_send_trigger,
    input  game_pkg::score_state_t score,
    output link_pkg::i2c_req_t     req,
    input  link_pkg::i2c_rsp_t     rsp,
    output logic                   busy
);
    import link_pkg::*;
    import game_pkg::*;

    typedef enum logic [2:0] {s_idle, s_start_wait, s_wait, s_send, s_stop, s_done} state_t;

    state_t       state, state_next;
    logic [1:0]   byte_cnt, byte_cnt_next;
    score_state_t snap;
    logic [7:0]   tx_data;
    logic         frame_sent;

    assign frame_sent = (byte_cnt == 2'(score_data_bytes + 1));
    assign busy       = (state != s_idle);

    always_ff @(posedge clk) begin
        if (state == s_idle && score_send_trigger && rsp.ready) begin
            snap <= score;
        end
    end

    always_comb begin
        case (byte_cnt)
            2'd0:    tx_data = score_slave_addr;
            2'd1:    tx_data = snap.score_left;
            default: tx_data = snap.score_right;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= s_idle;
            byte_cnt <= '0;
        end else begin
            state    <= state_next;
            byte_cnt <= byte_cnt_next;
        end
    end

    always_comb begin
        state_next    = state;
        byte_cnt_next = byte_cnt;
        req           = '0;
        req.data      = tx_data;
        req.en        = (state != s_idle) && (state != s_done);
        req.start     = (state == s_start_wait);
        req.stop      = (state == s_stop) || (state == s_wait && frame_sent);

        case (state)
            s_idle: begin
                byte_cnt_next = '0;
                if (score_send_trigger && rsp.ready) begin
                    state_next = s_start_wait;
                end
            end
            s_start_wait: if (!rsp.ready) state_next = s_wait;
            s_wait: begin
                if (rsp.nack) begin
                    state_next = s_idle;
                end else if (rsp.ready) begin
                    state_next = frame_sent ? s_stop : s_send;
                end
            end
            s_send: begin
                if (!rsp.ready) begin
                    state_next    = s_wait;
                    byte_cnt_next = byte_cnt + 2'd1;
                end
            end
            s_stop: if (!rsp.ready) state_next = s_done;
            s_done: if (rsp.ready) state_next = s_idle;  // stop finished on the bus
            default: state_next = s_idle;
        endcase
    end

endmodule

// ==== tb_i2c_link.sv ====
module tb_i2c_link;
    timeunit 1ns;
    timeprecision 100ps;
    import game_pkg::*;

    typedef struct packed {
        logic         fire_ball;
        logic         fire_score;
        ball_state_t  ball;
        score_state_t score;
        logic         nack;         // slave refuses every address byte
        logic [15:0]  abort_cycle;  // clocks after the trigger, 0 keeps the ball going right
    } row_t;

    localparam int n_directed = 6;
    localparam int n_rows     = 16;
    localparam int row_budget = 4 * 5 * 144 + 400;  // clocks per row
    localparam int clk_period = 100;

    logic         clk, reset;
    logic         ball_send_trigger, ball_moving_left, score_send_trigger;
    ball_state_t  ball;
    score_state_t score;
    logic         scl_oe, sda_oe, sda_in;
    logic         ball_busy, score_busy, nack_flag;
    logic [7:0]   status_led;

    logic         scl, sda;
    logic         ack_drive, nack_addr, in_frame;
    logic [7:0]   shift_reg;
    int           bit_cnt, cur_len, nack_cnt;
    logic [7:0]   rx_bytes[$];
    logic [7:0]   exp_bytes[$];
    int           rx_len[$];
    int           exp_len[$];
    bit           exp_cut[$];
    row_t         rows[n_rows];
    logic [31:0]  rng;
    int           error_count, ok_rows, bad_rows;

    i2c_link_top u_dut (
        .clk, .reset, .ball_send_trigger, .ball, .ball_moving_left, .score_send_trigger,
        .score, .scl_oe, .sda_oe, .sda_in, .ball_busy, .score_busy, .nack_flag, .status_led
    );

    // open-drain wires with pull-ups
    assign scl    = ~scl_oe;
    assign sda    = ~(sda_oe | ack_drive);
    assign sda_in = sda;

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(n_rows * row_budget * clk_period + 50 * clk_period);
        $display("timeout: the link did not finish all rows in the allowed time");
        $display("test failed");
        $finish;
    end

    // slave model
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            in_frame = 1'b1;  // start
            bit_cnt  = 0;
            cur_len  = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame) begin
            rx_len.push_back(cur_len);  // stop
            in_frame = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (in_frame) begin
            if (bit_cnt < 8) begin
                shift_reg = {shift_reg[6:0], sda};
            end
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                rx_bytes.push_back(shift_reg);
                cur_len = cur_len + 1;
            end else if (bit_cnt == 9) begin
                bit_cnt = 0;
            end
        end
    end

    // ack bit spans from this falling edge to the next one
    always @(negedge scl) begin
        if (in_frame && bit_cnt == 8) begin
            ack_drive <= !(nack_addr && cur_len == 1);
        end else begin
            ack_drive <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (nack_flag) begin
            nack_cnt++;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic row_t make_row(input logic fb, input logic fs, input logic [9:0] y,
                                      input logic [7:0] vy, input logic [7:0] left,
                                      input logic [7:0] right, input logic nack,
                                      input int abort_at);
        row_t row;
        row.fire_ball         = fb;
        row.fire_score        = fs;
        row.ball.ball_y       = y;
        row.ball.ball_vy      = vy;
        row.score.score_left  = left;
        row.score.score_right = right;
        row.nack              = nack;
        row.abort_cycle       = 16'(abort_at);
        return row;
    endfunction

    // ball frame goes first when both fire
    task automatic build_expected(input row_t row);
        exp_bytes.delete();
        exp_len.delete();
        exp_cut.delete();
        if (row.fire_ball) begin
            exp_bytes.push_back(8'haa);
            if (!row.nack) begin
                exp_bytes.push_back({row.ball.ball_y[9:8], 6'b0});
                exp_bytes.push_back(row.ball.ball_y[7:0]);
                exp_bytes.push_back(row.ball.ball_vy);
            end
            exp_len.push_back(row.nack ? 1 : 4);
            exp_cut.push_back(row.abort_cycle != 0);
        end
        if (row.fire_score) begin
            exp_bytes.push_back(8'hac);
            if (!row.nack) begin
                exp_bytes.push_back(row.score.score_left);
                exp_bytes.push_back(row.score.score_right);
            end
            exp_len.push_back(row.nack ? 1 : 3);
            exp_cut.push_back(1'b0);
        end
    endtask

    task automatic compare_frames();
        int rp;
        int ep;
        int n;
        int i;
        rp = 0;
        ep = 0;
        check_value("frame count", rx_len.size(), exp_len.size());
        if (rx_len.size() == exp_len.size()) begin
            foreach (exp_len[f]) begin
                if (exp_cut[f]) begin
                    check_value("aborted frame under four bytes", rx_len[f] < 4, 1);
                    check_value("aborted frame not empty", rx_len[f] > 0, 1);
                end else begin
                    check_value($sformatf("frame %0d length", f), rx_len[f], exp_len[f]);
                end
                n = (rx_len[f] < exp_len[f]) ? rx_len[f] : exp_len[f];
                for (i = 0; i < n; i++) begin
                    check_value($sformatf("frame %0d byte %0d", f, i),
                                rx_bytes[rp + i], exp_bytes[ep + i]);
                end
                rp += rx_len[f];
                ep += exp_len[f];
            end
        end
    endtask

    task automatic run_row(input row_t row);
        rx_bytes.delete();
        rx_len.delete();
        nack_cnt  = 0;
        nack_addr = row.nack;
        @(posedge clk);
        #1;
        ball               = row.ball;
        score              = row.score;
        ball_send_trigger  = row.fire_ball;
        score_send_trigger = row.fire_score;
        @(posedge clk);
        #1;
        ball_send_trigger  = 1'b0;
        score_send_trigger = 1'b0;
        if (row.abort_cycle != 0) begin
            repeat (row.abort_cycle - 1) @(posedge clk);
            #1;
            ball_moving_left = 1'b1;  // one clock is enough
            @(posedge clk);
            #1;
            ball_moving_left = 1'b0;
        end
        @(negedge clk);
        while (ball_busy || score_busy || !u_dut.bus_idle) begin
            @(negedge clk);
        end
        build_expected(row);
        compare_frames();
        check_value("nack pulses", nack_cnt,
                    row.nack ? (int'(row.fire_ball) + int'(row.fire_score)) : 0);
        check_value("status led in idle", status_led, 8'h01);
    endtask

    initial begin
        int r;
        int sel;
        int start_err;
        logic nack;
        reset              = 1'b1;
        ball_send_trigger  = 1'b0;
        ball_moving_left   = 1'b0;
        score_send_trigger = 1'b0;
        ball               = '0;
        score              = '0;
        ack_drive          = 1'b0;
        nack_addr          = 1'b0;
        in_frame           = 1'b0;
        shift_reg          = '0;
        bit_cnt            = 0;
        cur_len            = 0;
        nack_cnt           = 0;
        error_count        = 0;
        ok_rows            = 0;
        bad_rows           = 0;
        rng                = 32'hdee5_f3e5;

        rows[0] = make_row(1, 0, 10'h2c5, 8'h3b, 8'h00, 8'h00, 0, 0);
        rows[1] = make_row(0, 1, 10'h000, 8'h00, 8'h07, 8'h12, 0, 0);
        rows[2] = make_row(1, 1, 10'h1a7, 8'hf4, 8'h21, 8'h09, 0, 0);
        rows[3] = make_row(1, 0, 10'h3ff, 8'h81, 8'h00, 8'h00, 0, 200);
        rows[4] = make_row(1, 0, 10'h155, 8'h0c, 8'h00, 8'h00, 1, 0);
        rows[5] = make_row(0, 1, 10'h000, 8'h00, 8'h33, 8'h44, 1, 0);
        for (r = n_directed; r < n_rows; r++) begin
            rng = xorshift32(rng);
            sel = rng % 3;  // ball, score or both
            rng = xorshift32(rng);
            rows[r] = make_row(sel != 1, sel != 0, rng[9:0], rng[17:10], 8'h00, 8'h00, 0, 0);
            rng = xorshift32(rng);
            nack = (rng[18:16] == 3'd0);
            rows[r].score.score_left  = rng[7:0];
            rows[r].score.score_right = rng[15:8];
            rows[r].nack              = nack;
            if (rows[r].fire_ball && !nack && rng[21:20] == 2'd0) begin
                rng = xorshift32(rng);
                rows[r].abort_cycle = 16'(170 + rng % 260);  // inside data bytes 1 and 2
            end
        end

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        for (r = 0; r < n_rows; r++) begin
            start_err = error_count;
            run_row(rows[r]);
            if (error_count == start_err) begin
                ok_rows++;
                $display("row %0d ok, %0d frames", r, rx_len.size());
            end else begin
                bad_rows++;
                $display("row %0d bad, %0d errors", r, error_count - start_err);
            end
        end
        check_value("assertion failures", u_dut.u_chk.assert_fails, 0);

        $display("rows ok %0d, rows with errors %0d", ok_rows, bad_rows);
        if (bad_rows == 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
